// ==== design/mips_pkg.sv ====
`default_nettype none

package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_t;

    // primary opcodes
    localparam opcode_t OP_SPECIAL = 6'h00;
    localparam opcode_t OP_REGIMM  = 6'h01;
    localparam opcode_t OP_J       = 6'h02;
    localparam opcode_t OP_JAL     = 6'h03;
    localparam opcode_t OP_BEQ     = 6'h04;
    localparam opcode_t OP_BNE     = 6'h05;
    localparam opcode_t OP_ADDIU   = 6'h09;
    localparam opcode_t OP_SLTI    = 6'h0A;
    localparam opcode_t OP_ANDI    = 6'h0C;
    localparam opcode_t OP_ORI     = 6'h0D;
    localparam opcode_t OP_XORI    = 6'h0E;
    localparam opcode_t OP_LUI     = 6'h0F;
    localparam opcode_t OP_LB      = 6'h20;
    localparam opcode_t OP_LH      = 6'h21;
    localparam opcode_t OP_LW      = 6'h23;
    localparam opcode_t OP_LBU     = 6'h24;
    localparam opcode_t OP_LHU     = 6'h25;
    localparam opcode_t OP_SB      = 6'h28;
    localparam opcode_t OP_SH      = 6'h29;
    localparam opcode_t OP_SW      = 6'h2B;

    // function field of SPECIAL
    localparam funct_t FN_SLL   = 6'h00;
    localparam funct_t FN_SRL   = 6'h02;
    localparam funct_t FN_SRA   = 6'h03;
    localparam funct_t FN_JR    = 6'h08;
    localparam funct_t FN_JALR  = 6'h09;
    localparam funct_t FN_MFHI  = 6'h10;
    localparam funct_t FN_MFLO  = 6'h12;
    localparam funct_t FN_MULT  = 6'h18;
    localparam funct_t FN_MULTU = 6'h19;
    localparam funct_t FN_ADDU  = 6'h21;
    localparam funct_t FN_SUBU  = 6'h23;
    localparam funct_t FN_AND   = 6'h24;
    localparam funct_t FN_OR    = 6'h25;
    localparam funct_t FN_XOR   = 6'h26;
    localparam funct_t FN_NOR   = 6'h27;
    localparam funct_t FN_SLT   = 6'h2A;
    localparam funct_t FN_SLTU  = 6'h2B;

    localparam reg_idx_t REG_RA = 5'd31;

endpackage

`default_nettype wire

// ==== design/mips_decoder.sv ====
`default_nettype none

module mips_decoder
    import mips_pkg::*;
(
    input  wire word_t   instr,
    output alu_op_t      alu_op,
    output logic         use_imm,
    output logic         imm_zero_ext,
    output logic         reg_dst,
    output logic         reg_write,
    output logic         link,
    output logic         jump_imm,
    output logic         jump_reg,
    output logic         branch,
    output logic         load,
    output logic         store,
    output logic         partial_store,
    output logic         muldiv,
    output logic         mul_signed,
    output logic         move_hi,
    output logic         move_lo,
    output reg_idx_t     write_index
);
    opcode_t opcode;
    funct_t  funct;
    logic    link_const;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];

    always_comb begin
        alu_op       = ALU_ADD;
        use_imm      = 1'b0;
        imm_zero_ext = 1'b0;
        reg_write    = 1'b0;
        link_const   = 1'b0;
        link         = 1'b0;
        jump_imm     = 1'b0;
        jump_reg     = 1'b0;
        branch       = 1'b0;
        muldiv       = 1'b0;
        mul_signed   = 1'b0;
        move_hi      = 1'b0;
        move_lo      = 1'b0;
        case (opcode)
            OP_SPECIAL: begin
                reg_write = 1'b1;
                case (funct)
                    FN_ADDU: alu_op = ALU_ADD;
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_XOR:  alu_op = ALU_XOR;
                    FN_NOR:  alu_op = ALU_NOR;
                    FN_SLT:  alu_op = ALU_SLT;
                    FN_SLTU: alu_op = ALU_SLTU;
                    FN_SLL:  alu_op = ALU_SLL;
                    FN_SRL:  alu_op = ALU_SRL;
                    FN_SRA:  alu_op = ALU_SRA;
                    FN_MFHI: move_hi = 1'b1;
                    FN_MFLO: move_lo = 1'b1;
                    FN_JR: begin
                        jump_reg  = 1'b1;
                        reg_write = 1'b0;
                    end
                    // jalr links into rd
                    FN_JALR: begin
                        jump_reg = 1'b1;
                        link     = 1'b1;
                    end
                    FN_MULT, FN_MULTU: begin
                        muldiv     = 1'b1;
                        mul_signed = (funct == FN_MULT);
                        reg_write  = 1'b0;
                    end
                    default: reg_write = 1'b0;
                endcase
            end
            // bltzal and bgezal have rt bit 4 set
            OP_REGIMM: begin
                branch     = 1'b1;
                link_const = instr[20];
                link       = instr[20];
                reg_write  = instr[20];
            end
            OP_J: jump_imm = 1'b1;
            OP_JAL: begin
                jump_imm   = 1'b1;
                link_const = 1'b1;
                link       = 1'b1;
                reg_write  = 1'b1;
            end
            OP_BEQ, OP_BNE: branch = 1'b1;
            OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                use_imm      = 1'b1;
                reg_write    = 1'b1;
                imm_zero_ext = opcode inside {OP_ANDI, OP_ORI, OP_XORI};
                case (opcode)
                    OP_SLTI: alu_op = ALU_SLT;
                    OP_ANDI: alu_op = ALU_AND;
                    OP_ORI:  alu_op = ALU_OR;
                    OP_XORI: alu_op = ALU_XOR;
                    OP_LUI:  alu_op = ALU_LUI;
                    default: alu_op = ALU_ADD;
                endcase
            end
            OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU: reg_write = 1'b1;
            default: reg_write = 1'b0;
        endcase
    end

    assign load          = opcode inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};
    assign store         = opcode inside {OP_SB, OP_SH, OP_SW};
    assign partial_store = opcode inside {OP_SB, OP_SH};
    assign reg_dst       = (opcode == OP_SPECIAL);

    assign write_index = link_const ? REG_RA : (reg_dst ? instr[15:11] : instr[20:16]);

endmodule

`default_nettype wire

// ==== design/mips_pc_unit.sv ====
`default_nettype none

module mips_pc_unit
    import mips_pkg::*;
#(
    parameter word_t RESET_VECTOR = 32'hBFC0_0000
) (
    input  wire         clk,
    input  wire         reset,
    input  wire         clk_enable,
    input  wire         take_branch,
    input  wire         jump_imm,
    input  wire         jump_reg,
    input  wire word_t  instr,
    input  wire word_t  reg_target,
    output word_t       pc,
    output word_t       link_addr,
    output logic        exec_phase,
    output logic        active
);
    word_t delay_slot;
    word_t next_slot;
    word_t branch_offset;

    // word offset relative to the delay slot
    assign branch_offset = {{14{instr[15]}}, instr[15:0], 2'b00};
    assign link_addr     = delay_slot + 32'd4;

    always_comb begin
        if (take_branch) begin
            next_slot = delay_slot + branch_offset;
        end else if (jump_imm) begin
            next_slot = {delay_slot[31:28], instr[25:0], 2'b00};
        end else if (jump_reg) begin
            next_slot = reg_target;
        end else begin
            next_slot = link_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc         <= RESET_VECTOR;
            delay_slot <= RESET_VECTOR + 32'd4;
            exec_phase <= 1'b0;
            active     <= 1'b1;
        end else if (clk_enable && active) begin
            exec_phase <= !exec_phase;
            // end of execute
            if (exec_phase) begin
                pc         <= delay_slot;
                delay_slot <= next_slot;
                if (pc == '0) begin
                    active <= 1'b0;
                end
            end
        end
    end

    // a halted core stays halted until reset
    a_no_wake: assert property (@(posedge clk) $rose(active) |-> $past(reset));

endmodule

`default_nettype wire

// ==== design/mips_regfile.sv ====
`default_nettype none

module mips_regfile
    import mips_pkg::*;
(
    input  wire            clk,
    input  wire            reset,
    input  wire            clk_enable,
    input  wire reg_idx_t  rs,
    input  wire reg_idx_t  rt,
    input  wire reg_idx_t  write_index,
    input  wire            write_enable,
    input  wire word_t     write_data,
    output word_t          rs_data,
    output word_t          rt_data,
    output word_t          register_v0
);
    // r0 has no storage
    word_t regs [1:31];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (clk_enable && write_enable && write_index != '0) begin
            regs[write_index] <= write_data;
        end
    end

    assign rs_data     = (rs == '0) ? '0 : regs[rs];
    assign rt_data     = (rt == '0) ? '0 : regs[rt];
    assign register_v0 = regs[2];

    // a committed write carries a known index and value
    a_write_known: assert property (@(posedge clk) disable iff (reset)
        clk_enable && write_enable |-> !$isunknown({write_index, write_data}));

endmodule

`default_nettype wire

// ==== design/mips_alu.sv ====
`default_nettype none

module mips_alu
    import mips_pkg::*;
(
    input  wire alu_op_t  op,
    input  wire word_t    a,
    input  wire word_t    b,
    input  wire word_t    instr,
    input  wire           use_imm,
    input  wire           imm_zero_ext,
    output word_t         result,
    output word_t         eff_addr,
    output logic          take_branch
);
    word_t      sext_imm;
    word_t      operand_b;
    logic [4:0] shamt;

    assign sext_imm  = {{16{instr[15]}}, instr[15:0]};
    assign operand_b = use_imm ? (imm_zero_ext ? {16'h0000, instr[15:0]} : sext_imm) : b;
    assign shamt     = instr[10:6];

    always_comb begin
        case (op)
            ALU_ADD:  result = a + operand_b;
            ALU_SUB:  result = a - operand_b;
            ALU_AND:  result = a & operand_b;
            ALU_OR:   result = a | operand_b;
            ALU_XOR:  result = a ^ operand_b;
            ALU_NOR:  result = ~(a | operand_b);
            ALU_SLT:  result = {31'd0, $signed(a) < $signed(operand_b)};
            ALU_SLTU: result = {31'd0, a < operand_b};
            // shifts take rt and the shamt field
            ALU_SLL:  result = b << shamt;
            ALU_SRL:  result = b >> shamt;
            ALU_SRA:  result = $signed(b) >>> shamt;
            ALU_LUI:  result = {instr[15:0], 16'h0000};
            default:  result = a + operand_b;
        endcase
    end

    assign eff_addr = a + sext_imm;

    // condition only, the decoder says whether this is a branch at all
    always_comb begin
        if (instr[31:26] == OP_REGIMM) begin
            // rt bit 0 selects bgez over bltz
            take_branch = instr[16] ? !a[31] : a[31];
        end else if (instr[26]) begin
            take_branch = (a != b);
        end else begin
            take_branch = (a == b);
        end
    end

endmodule

`default_nettype wire

// ==== design/mips_mul_unit.sv ====
`default_nettype none

module mips_mul_unit
    import mips_pkg::*;
(
    input  wire         clk,
    input  wire         reset,
    input  wire         enable,
    input  wire         is_signed,
    input  wire word_t  a,
    input  wire word_t  b,
    output word_t       hi,
    output word_t       lo
);
    logic [63:0] a_ext;
    logic [63:0] b_ext;
    logic [63:0] product;

    // low 64 bits of the extended product are right for both signednesses
    assign a_ext   = {{32{is_signed & a[31]}}, a};
    assign b_ext   = {{32{is_signed & b[31]}}, b};
    assign product = a_ext * b_ext;

    always_ff @(posedge clk) begin
        if (reset) begin
            hi <= '0;
            lo <= '0;
        end else if (enable) begin
            hi <= product[63:32];
            lo <= product[31:0];
        end
    end

endmodule

`default_nettype wire

// ==== design/mips_mem_align.sv ====
`default_nettype none

module mips_mem_align
    import mips_pkg::*;
(
    input  wire opcode_t  opcode,
    input  wire [1:0]     byte_offset,
    input  wire word_t    mem_word,
    input  wire word_t    reg_word,
    output word_t         load_value,
    output word_t         store_word
);
    logic [4:0]  byte_lsb;
    logic [7:0]  mem_byte;
    logic [15:0] mem_half;

    // big endian, offset 0 is the top byte
    assign byte_lsb = {~byte_offset, 3'b000};
    assign mem_byte = mem_word[byte_lsb +: 8];
    assign mem_half = byte_offset[1] ? mem_word[15:0] : mem_word[31:16];

    always_comb begin
        case (opcode)
            OP_LB:   load_value = {{24{mem_byte[7]}}, mem_byte};
            OP_LBU:  load_value = {24'h000000, mem_byte};
            OP_LH:   load_value = {{16{mem_half[15]}}, mem_half};
            OP_LHU:  load_value = {16'h0000, mem_half};
            default: load_value = mem_word;
        endcase
    end

    // sb and sh patch the old word
    always_comb begin
        store_word = reg_word;
        if (opcode == OP_SB) begin
            store_word = mem_word;
            store_word[byte_lsb +: 8] = reg_word[7:0];
        end else if (opcode == OP_SH) begin
            store_word = byte_offset[1] ? {mem_word[31:16], reg_word[15:0]}
                                        : {reg_word[15:0], mem_word[15:0]};
        end
    end

    a_half_aligned: assert final ($isunknown(opcode) ||
        !(opcode inside {OP_LH, OP_LHU, OP_SH}) || !byte_offset[0]);
    a_word_aligned: assert final ($isunknown(opcode) ||
        !(opcode inside {OP_LW, OP_SW}) || byte_offset == 2'b00);

endmodule

`default_nettype wire

// ==== design/mips_cpu_harvard.sv ====
`default_nettype none

module mips_cpu_harvard
    import mips_pkg::*;
#(
    parameter word_t RESET_VECTOR = 32'hBFC0_0000
) (
    input  wire         clk,
    input  wire         reset,
    input  wire         clk_enable,
    output logic        active,
    output word_t       register_v0,
    output word_t       instr_address,
    input  wire word_t  instr_readdata,
    output word_t       data_address,
    output logic        data_write,
    output logic        data_read,
    output word_t       data_writedata,
    input  wire word_t  data_readdata
);
    alu_op_t  alu_op;
    logic     use_imm, imm_zero_ext, reg_write, link, jump_imm, jump_reg, branch;
    logic     load, store, partial_store, muldiv, mul_signed, move_hi, move_lo;
    reg_idx_t write_index;
    word_t    pc, link_addr, rs_data, rt_data, write_data;
    word_t    alu_result, eff_addr, hi, lo, load_value, old_word, mem_word;
    logic     exec_phase, alu_cond, exec_enable;

    mips_decoder mips_decoder_i (
        .instr(instr_readdata), .alu_op(alu_op), .use_imm(use_imm),
        .imm_zero_ext(imm_zero_ext), .reg_dst(), .reg_write(reg_write), .link(link),
        .jump_imm(jump_imm), .jump_reg(jump_reg), .branch(branch), .load(load),
        .store(store), .partial_store(partial_store), .muldiv(muldiv),
        .mul_signed(mul_signed), .move_hi(move_hi), .move_lo(move_lo),
        .write_index(write_index)
    );

    mips_pc_unit #(.RESET_VECTOR(RESET_VECTOR)) mips_pc_unit_i (
        .clk(clk), .reset(reset), .clk_enable(clk_enable),
        .take_branch(branch && alu_cond), .jump_imm(jump_imm), .jump_reg(jump_reg),
        .instr(instr_readdata), .reg_target(rs_data), .pc(pc), .link_addr(link_addr),
        .exec_phase(exec_phase), .active(active)
    );

    // commit point of an instruction
    assign exec_enable = exec_phase && active;

    mips_regfile mips_regfile_i (
        .clk(clk), .reset(reset), .clk_enable(clk_enable),
        .rs(instr_readdata[25:21]), .rt(instr_readdata[20:16]),
        .write_index(write_index), .write_enable(exec_enable && reg_write),
        .write_data(write_data), .rs_data(rs_data), .rt_data(rt_data),
        .register_v0(register_v0)
    );

    mips_alu mips_alu_i (
        .op(alu_op), .a(rs_data), .b(rt_data), .instr(instr_readdata),
        .use_imm(use_imm), .imm_zero_ext(imm_zero_ext), .result(alu_result),
        .eff_addr(eff_addr), .take_branch(alu_cond)
    );

    mips_mul_unit mips_mul_unit_i (
        .clk(clk), .reset(reset), .enable(exec_enable && clk_enable && muldiv),
        .is_signed(mul_signed), .a(rs_data), .b(rt_data), .hi(hi), .lo(lo)
    );

    // old word of a partial store, read during fetch
    always_ff @(posedge clk) begin
        if (clk_enable && !exec_phase) begin
            old_word <= data_readdata;
        end
    end

    assign mem_word = partial_store ? old_word : data_readdata;

    mips_mem_align mips_mem_align_i (
        .opcode(instr_readdata[31:26]), .byte_offset(eff_addr[1:0]),
        .mem_word(mem_word), .reg_word(rt_data), .load_value(load_value),
        .store_word(data_writedata)
    );

    assign write_data = link ? link_addr :
                        move_hi ? hi :
                        move_lo ? lo :
                        load ? load_value : alu_result;

    assign instr_address = pc;
    assign data_address  = {eff_addr[31:2], 2'b00};
    assign data_write    = exec_enable && store;
    assign data_read     = active && (load || (partial_store && !exec_phase));

endmodule

`default_nettype wire

// ==== sim/tb_mips_cpu.sv ====
`default_nettype none

module tb_mips_cpu
    import mips_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam word_t RESET_VECTOR = 32'hBFC0_0000;
    localparam int    MAX_CYCLES   = 4000;

    logic  clk;
    logic  reset;
    logic  clk_enable;
    logic  active;
    word_t register_v0;
    word_t instr_address;
    word_t instr_readdata;
    word_t data_address;
    logic  data_write;
    logic  data_read;
    word_t data_writedata;
    word_t data_readdata;

    word_t  rom [0:127];
    word_t  ram [0:255];
    word_t  exp_addr [$];
    word_t  exp_data [$];
    integer seed = 57;

    mips_cpu_harvard #(.RESET_VECTOR(RESET_VECTOR)) mips_cpu_harvard_i (
        .clk(clk), .reset(reset), .clk_enable(clk_enable), .active(active),
        .register_v0(register_v0), .instr_address(instr_address),
        .instr_readdata(instr_readdata), .data_address(data_address),
        .data_write(data_write), .data_read(data_read),
        .data_writedata(data_writedata), .data_readdata(data_readdata)
    );

    // rom covers the boot region only, everything else reads as nop
    assign instr_readdata = (instr_address[31:9] == RESET_VECTOR[31:9]) ?
                            rom[instr_address[8:2]] : '0;
    assign data_readdata  = ram[data_address[9:2]];

    always @(posedge clk) begin
        if (clk_enable && data_write) begin
            ram[data_address[9:2]] <= data_writedata;
        end
    end

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // roughly four enabled cycles in five
    always @(posedge clk) begin
        clk_enable <= ($random(seed) % 5) != 0;
    end

    task automatic stop_with(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_word(input word_t got, input word_t expected, input string what);
        if (got !== expected) begin
            stop_with($sformatf("Mismatch at %0t: %s is %h, expected %h",
                                $time, what, got, expected));
        end
    endtask

    task automatic check_addr(input word_t got, input word_t expected, input string what);
        if (got !== expected) begin
            stop_with($sformatf("Mismatch at %0t: %s is %h, expected %h",
                                $time, what, got, expected));
        end
    endtask

    task automatic check_bit(input logic got, input logic expected, input string what);
        if (got !== expected) begin
            stop_with($sformatf("Mismatch at %0t: %s is %b, expected %b",
                                $time, what, got, expected));
        end
    endtask

    task automatic require_fields(input int got, input int want);
        if (got != want) begin
            stop_with("a line of the trace file is missing a field");
        end
    endtask

    // loads read in both phases, sb and sh only while they fetch
    function automatic logic expected_data_read(input opcode_t op, input logic exec);
        logic is_load;
        logic is_partial;
        is_load    = (op == OP_LB) || (op == OP_LH) || (op == OP_LW) ||
                     (op == OP_LBU) || (op == OP_LHU);
        is_partial = (op == OP_SB) || (op == OP_SH);
        return is_load || (is_partial && !exec);
    endfunction

    task automatic clear_memories();
        for (int i = 0; i < 128; i++) begin
            rom[i] = '0;
        end
        for (int i = 0; i < 256; i++) begin
            ram[i] = '0;
        end
    endtask

    task automatic run_program(input word_t exp_v0);
        int   cycles;
        logic in_exec;
        @(posedge clk);
        reset <= 1'b1;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_bit(active, 1'b1, "active after reset");
        check_bit(data_write, 1'b0, "data_write after reset");
        check_addr(instr_address, RESET_VECTOR, "instr_address after reset");
        cycles  = 0;
        in_exec = 1'b0;
        while (active === 1'b1) begin
            check_bit(data_read, expected_data_read(instr_readdata[31:26], in_exec),
                      "data_read");
            if (clk_enable && data_write) begin
                if (exp_addr.size() == 0) begin
                    stop_with("the core wrote data memory more often than expected");
                end else begin
                    check_addr(data_address, exp_addr.pop_front(), "store address");
                    check_word(data_writedata, exp_data.pop_front(), "store data");
                end
            end
            // two enabled cycles per instruction, fetch first
            if (clk_enable) begin
                in_exec = !in_exec;
            end
            cycles++;
            if (cycles > MAX_CYCLES) begin
                stop_with("timeout, the core never halted");
            end else begin
                @(negedge clk);
            end
        end
        // halted core stays quiet
        repeat (20) begin
            @(negedge clk);
            check_bit(active, 1'b0, "active after halt");
            check_bit(data_write, 1'b0, "data_write after halt");
        end
        if (exp_addr.size() != 0) begin
            stop_with("some expected stores never happened");
        end
        check_word(register_v0, exp_v0, "register_v0");
    endtask

    initial begin
        int         fd;
        int         code;
        int         programs;
        logic [7:0] kind;
        word_t      a;
        word_t      b;
        string      line;
        reset      = 1'b1;
        clk_enable = 1'b0;
        programs   = 0;
        clear_memories();
        fd = $fopen("sim/mips_trace.txt", "r");
        if (fd == 0) begin
            stop_with("cannot open sim/mips_trace.txt");
        end
        while ($fscanf(fd, " %c", kind) == 1) begin
            case (kind)
                "#": code = $fgets(line, fd);
                "I": begin
                    code = $fscanf(fd, "%h %h", a, b);
                    require_fields(code, 2);
                    rom[a[8:2]] = b;
                end
                "D": begin
                    code = $fscanf(fd, "%h %h", a, b);
                    require_fields(code, 2);
                    ram[a[9:2]] = b;
                end
                "S": begin
                    code = $fscanf(fd, "%h %h", a, b);
                    require_fields(code, 2);
                    exp_addr.push_back(a);
                    exp_data.push_back(b);
                end
                // v0 line closes a program
                "V": begin
                    code = $fscanf(fd, "%h", a);
                    require_fields(code, 1);
                    run_program(a);
                    clear_memories();
                    programs++;
                end
                default: stop_with("unknown line kind in the trace file");
            endcase
        end
        $fclose(fd);
        if (programs == 0) begin
            stop_with("the trace file holds no program");
        end else begin
            $display("Test OK");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== sim/mips_trace.txt ====
# I addr instr | D addr data | S addr data (expected store, in order)
# V v0 ends a program and runs it
I bfc00000 3c081234
I bfc00004 35085678
I bfc00008 2409fffd
I bfc0000c 00095043
I bfc00010 00095f02
I bfc00014 00086100
I bfc00018 01886823
I bfc0001c 01ab7026
I bfc00020 0120782a
I bfc00024 0009802b
I bfc00028 2931fffe
I bfc0002c 3112ff0f
I bfc00030 3a53ffff
I bfc00034 01280018
I bfc00038 0000a010
I bfc0003c 0000a812
I bfc00040 01280019
I bfc00044 0000b010
I bfc00048 02ccb821
I bfc0004c 02e8c024
I bfc00050 03131025
I bfc00054 ac0a0100
I bfc00058 ac0b0104
I bfc0005c ac0e0108
I bfc00060 ac0f010c
I bfc00064 ac100110
I bfc00068 ac110114
I bfc0006c ac130118
I bfc00070 ac14011c
I bfc00074 ac150120
I bfc00078 00000008
I bfc0007c 00000000
S 00000100 fffffffe
S 00000104 0000000f
S 00000108 11111107
S 0000010c 00000001
S 00000110 00000001
S 00000114 00000001
S 00000118 0000a9f7
S 0000011c ffffffff
S 00000120 c962fc98
V 1030bdf7
I bfc00000 80090201
I bfc00004 900a0202
I bfc00008 840b0204
I bfc0000c 940c0206
I bfc00010 a0090205
I bfc00014 a40a0202
I bfc00018 ac0b0208
I bfc0001c 8c0d0204
I bfc00020 018a7021
I bfc00024 01ae1021
I bfc00028 00000008
I bfc0002c 00000000
D 00000200 8091a2b3
D 00000204 c4d5e6f7
S 00000204 c491e6f7
S 00000200 809100a2
S 00000208 ffffc4d5
V c492ce90
I bfc00000 24080005
I bfc00004 11000003
I bfc00008 24020001
I bfc0000c 15000002
I bfc00010 24420002
I bfc00014 24420100
I bfc00018 0ff0000c
I bfc0001c 24420004
I bfc00020 0bf00016
I bfc00024 24420010
I bfc00030 03e04821
I bfc00034 05110003
I bfc00038 ac1f0300
I bfc0003c 24420200
I bfc00044 05100008
I bfc00048 ac1f0304
I bfc0004c 01200008
I bfc00050 24420040
I bfc00058 00001809
I bfc0005c 00431021
S 00000300 bfc0003c
S 00000304 bfc0004c
V bfc000b7

// ==== files.f ====
design/mips_pkg.sv
design/mips_decoder.sv
design/mips_pc_unit.sv
design/mips_regfile.sv
design/mips_alu.sv
design/mips_mul_unit.sv
design/mips_mem_align.sv
design/mips_cpu_harvard.sv
sim/tb_mips_cpu.sv

// ==== Bender.yml ====
package:
  name: mips_cpu_harvard

sources:
  - files:
      - design/mips_pkg.sv
      - design/mips_decoder.sv
      - design/mips_pc_unit.sv
      - design/mips_regfile.sv
      - design/mips_alu.sv
      - design/mips_mul_unit.sv
      - design/mips_mem_align.sv
      - design/mips_cpu_harvard.sv
  - target: simulation
    files:
      - sim/tb_mips_cpu.sv
